// File: bench/servo_top_tb.sv
`timescale 1ns/1ns

module servo_top_tb;

	import servo_pkg::*;

	// a few hundred cycles of tests, generous margin
	localparam int WATCHDOG_NS = 20000;
	localparam longint SIG_HI = (longint'(1) <<< (SIGNAL_W - 1)) - 1;
	localparam longint SIG_LO = -SIG_HI - 1;

	logic                       clk1;
	logic                       rst_n;
	logic                       wb_cyc;
	logic                       wb_stb;
	logic                       wb_we;
	logic [WB_AW-1:0]           wb_adr;
	logic [WB_DW-1:0]           wb_wdat;
	logic [WB_DW-1:0]           wb_rdat;
	logic                       wb_ack;
	logic signed [ADC_W-1:0]    adc0;
	logic signed [ADC_W-1:0]    adc1;
	logic                       sample_valid;
	logic signed [DAC_W-1:0]    dac_word;
	logic                       dac_valid;
	logic signed [SIGNAL_W-1:0] err_out;
	logic [1:0]                 afe_gain0;
	logic [1:0]                 afe_gain1;

	// model state, per channel
	logic   on_m [2];
	longint coef_m [2][3];
	longint y_st [2];
	longint xp_st [2];
	// expected outputs, two stages deep
	logic   exp_v [2];
	longint exp_e [2];
	int     n_err;
	int     n_checks;
	int     n_out;

	tb_clock clock_i (
		.o_clk1(clk1),
		.o_rst_n(rst_n)
	);

	servo_top servo_top_i (
		.clk1(clk1),
		.i_rst_n(rst_n),
		.i_wb_cyc(wb_cyc),
		.i_wb_stb(wb_stb),
		.i_wb_we(wb_we),
		.i_wb_adr(wb_adr),
		.i_wb_dat(wb_wdat),
		.o_wb_dat(wb_rdat),
		.o_wb_ack(wb_ack),
		.i_adc0(adc0),
		.i_adc1(adc1),
		.i_sample_valid(sample_valid),
		.o_dac_word(dac_word),
		.o_dac_valid(dac_valid),
		.o_error(err_out),
		.o_afe_gain0(afe_gain0),
		.o_afe_gain1(afe_gain1)
	);

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	function automatic longint sat(input longint v, input int w);
		longint hi;
		hi = (longint'(1) <<< (w - 1)) - 1;
		if (v > hi) return hi;
		if (v < -hi - 1) return -hi - 1;
		return v;
	endfunction

	// one sample through one channel, history kept in bypass as well
	function automatic longint filter_step(input int ch, input longint sample);
		longint xs;
		longint acc;
		longint y;
		xs = sample * (longint'(1) <<< (SIGNAL_W - ADC_W));
		if (on_m[ch]) begin
			acc = coef_m[ch][0] * y_st[ch] + coef_m[ch][1] * xs + coef_m[ch][2] * xp_st[ch];
			y = sat(acc >>> COEF_FRAC, SIGNAL_W);
		end else begin
			y = xs;
		end
		y_st[ch] = y;
		xp_st[ch] = xs;
		return y;
	endfunction

	task automatic compare(input longint got, input longint exp, input string what);
		n_checks++;
		assert (got == exp) else begin
			n_err++;
			$display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// drivers
	//////////////////////////////////////////////////////////////////////

	// one clock of the sample path, outputs checked 1 ns after the edge
	task automatic drive_cycle(input logic v, input logic signed [ADC_W-1:0] a0,
			input logic signed [ADC_W-1:0] a1);
		longint e;
		sample_valid = v;
		adc0 = a0;
		adc1 = a1;
		e = 0;
		if (v) begin
			e = sat(filter_step(0, a0) - filter_step(1, a1), SIGNAL_W);
		end
		@(posedge clk1);
		#1;
		exp_v[1] = exp_v[0];
		exp_e[1] = exp_e[0];
		exp_v[0] = v;
		exp_e[0] = e;
		compare(dac_valid, exp_v[1], "o_dac_valid");
		if (exp_v[1]) begin
			compare(err_out, exp_e[1], "o_error");
			compare(dac_word, exp_e[1] >>> (SIGNAL_W - DAC_W), "o_dac_word");
		end
		// strobes actually seen from the dut
		if (dac_valid) begin
			n_out++;
		end
	endtask

	task automatic drain_pipe();
		repeat (2) drive_cycle(1'b0, '0, '0);
	endtask

	// one wishbone classic transfer, waits for ack with a limit
	task automatic bus_access(input logic we, input logic [WB_AW-1:0] adr,
			input logic [WB_DW-1:0] wdat, output logic [WB_DW-1:0] rdat, output int lat);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_wdat = wdat;
		lat = 0;
		do begin
			@(posedge clk1);
			#1;
			lat++;
		end while (!wb_ack && lat < 16);
		assert (wb_ack) else begin
			n_err++;
			$display("register bank gave no ack at %0t ns for address %0d", $time, adr);
		end
		rdat = wb_rdat;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		// ack gap
		@(posedge clk1);
		#1;
	endtask

	// write and mirror into the model
	task automatic write_config(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] val);
		logic [WB_DW-1:0] rd;
		int lat;
		bus_access(1'b1, adr, val, rd, lat);
		if (adr == 1) begin
			on_m[0] = val[0];
			on_m[1] = val[1];
		end else if (adr >= 2 && adr <= 7) begin
			coef_m[(adr - 2) / 3][(adr - 2) % 3] = longint'(signed'(val[COEF_W-1:0]));
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		$display("%s done, %0d errors", name, n_err - err_before);
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic check_reset_state();
		int e0;
		logic [WB_DW-1:0] rd;
		int lat;
		e0 = n_err;
		compare(wb_ack, 0, "o_wb_ack");
		compare(dac_valid, 0, "o_dac_valid");
		compare(err_out, 0, "o_error");
		compare(afe_gain0, 3, "o_afe_gain0");
		compare(afe_gain1, 3, "o_afe_gain1");
		bus_access(1'b0, 0, '0, rd, lat);
		compare(rd, 32'h12, "version word");
		compare(lat, 1, "ack latency");
		report_test("reset values", e0);
	endtask

	task automatic exercise_registers();
		int e0;
		int lat;
		logic [WB_DW-1:0] v;
		logic [WB_DW-1:0] rd;
		logic [WB_DW-1:0] exp;
		e0 = n_err;
		for (int a = 1; a <= 7; a++) begin
			v = $urandom;
			write_config(a[WB_AW-1:0], v);
			bus_access(1'b0, a[WB_AW-1:0], '0, rd, lat);
			if (a == 1) begin
				exp = v & 32'h3f;
				compare(afe_gain0, 2'd3 - v[3:2], "o_afe_gain0");
				compare(afe_gain1, 2'd3 - v[5:4], "o_afe_gain1");
			end else begin
				exp = {{(WB_DW - COEF_W){v[COEF_W-1]}}, v[COEF_W-1:0]};
			end
			compare(rd, exp, "register read back");
		end
		// addresses 8 and up are holes
		bus_access(1'b0, WB_AW'($urandom_range(15, 8)), '0, rd, lat);
		compare(rd, 0, "unmapped read");
		report_test("register access", e0);
	endtask

	task automatic run_bypass_pairs();
		int e0;
		int sent;
		logic v;
		e0 = n_err;
		write_config(1, 32'h0);
		n_out = 0;
		sent = 0;
		for (int i = 0; i < 24; i++) begin
			v = 1'($urandom_range(1));
			sent += v;
			drive_cycle(v, ADC_W'($urandom), ADC_W'($urandom));
		end
		drain_pipe();
		compare(n_out, sent, "bypass output count");
		report_test("bypass difference", e0);
	endtask

	task automatic run_filtered_sequence();
		int e0;
		int c;
		e0 = n_err;
		// coefficients below half of one in magnitude
		for (int a = 2; a <= 7; a++) begin
			c = $urandom_range(32767);
			if ($urandom_range(1) == 1) begin
				c = -c;
			end
			write_config(a[WB_AW-1:0], 32'(c));
		end
		write_config(1, 32'h3);
		for (int i = 0; i < 16; i++) begin
			drive_cycle(1'b1, ADC_W'($urandom), ADC_W'($urandom));
			drive_cycle(1'b0, '0, '0);
		end
		// step on both channels
		for (int i = 0; i < 12; i++) begin
			drive_cycle(1'b1, 16'sh4000, -16'sh2000);
		end
		drain_pipe();
		report_test("filtered path", e0);
	endtask

	task automatic stream_back_to_back();
		int e0;
		e0 = n_err;
		n_out = 0;
		for (int i = 0; i < 32; i++) begin
			drive_cycle(1'b1, ADC_W'($urandom), ADC_W'($urandom));
		end
		drain_pipe();
		compare(n_out, 32, "back to back output count");
		report_test("back to back throughput", e0);
	endtask

	task automatic drive_saturation();
		int e0;
		e0 = n_err;
		write_config(1, 32'h0);
		drive_cycle(1'b1, 16'sh7fff, 16'sh8000);
		drain_pipe();
		compare(err_out, SIG_HI, "positive limit error");
		compare(dac_word, 32767, "positive limit dac word");
		drive_cycle(1'b1, 16'sh8000, 16'sh7fff);
		drain_pipe();
		compare(err_out, SIG_LO, "negative limit error");
		compare(dac_word, -32768, "negative limit dac word");
		report_test("saturation", e0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// sequence and watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(59));
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_wdat = '0;
		adc0 = '0;
		adc1 = '0;
		sample_valid = 1'b0;
		n_err = 0;
		n_checks = 0;
		n_out = 0;
		for (int ch = 0; ch < 2; ch++) begin
			on_m[ch] = 1'b0;
			y_st[ch] = 0;
			xp_st[ch] = 0;
			exp_v[ch] = 1'b0;
			exp_e[ch] = 0;
			for (int k = 0; k < 3; k++) begin
				coef_m[ch][k] = 0;
			end
		end
		@(posedge rst_n);
		@(posedge clk1);
		#1;
		check_reset_state();
		exercise_registers();
		run_bypass_pairs();
		run_filtered_sequence();
		stream_back_to_back();
		drive_saturation();
		$display("6 tests, %0d checks, %0d errors", n_checks, n_err);
		if (n_err == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		#WATCHDOG_NS;
		$display("run timed out after %0d ns", WATCHDOG_NS);
		$display("Testbench failed");
		$finish;
	end

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
	output logic o_clk1,
	output logic o_rst_n
);

	// 4 ns period
	initial begin
		o_clk1 = 1'b0;
		forever #2 o_clk1 = ~o_clk1;
	end

	// reset low for three rising edges, released just after the third
	initial begin
		o_rst_n = 1'b0;
		repeat (3) @(posedge o_clk1);
		#1 o_rst_n = 1'b1;
	end

endmodule

// File: run.sh
#!/bin/sh
# build and run the servo testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module servo_top_tb -f servo_top.f

out=$(./obj_dir/Vservo_top_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Testbench passed"; then
	exit 0
fi
exit 1

// File: servo_top.f
verilog/servo_pkg.sv
verilog/iir_first_order.sv
verilog/channel_diff.sv
verilog/servo_regs.sv
verilog/servo_top.sv
bench/tb_clock.sv
bench/servo_top_tb.sv

// File: verilog/channel_diff.sv
`timescale 1ns/1ns

module channel_diff #(
	parameter int SIGNAL_W = servo_pkg::SIGNAL_W,
	parameter int DAC_W    = servo_pkg::DAC_W
) (
	input  logic                        clk1,
	input  logic                        i_rst_n,
	input  logic signed [SIGNAL_W-1:0]  i_sig0,
	input  logic signed [SIGNAL_W-1:0]  i_sig1,
	input  logic                        i_valid0,
	input  logic                        i_valid1,
	output logic signed [SIGNAL_W-1:0]  o_error,
	output logic signed [DAC_W-1:0]     o_dac_word,
	output logic                        o_dac_valid
);

	localparam logic signed [SIGNAL_W-1:0] SIG_MAX = {1'b0, {(SIGNAL_W-1){1'b1}}};
	localparam logic signed [SIGNAL_W-1:0] SIG_MIN = {1'b1, {(SIGNAL_W-1){1'b0}}};

	// one extra bit so the subtraction never wraps
	logic signed [SIGNAL_W:0]   diff;
	logic signed [SIGNAL_W-1:0] diff_sat;
	logic                       valid;

	assign valid = i_valid0 & i_valid1;
	assign diff = i_sig0 - i_sig1;

	// top two bits disagree on overflow
	always_comb begin
		if (diff[SIGNAL_W] == diff[SIGNAL_W-1]) begin
			diff_sat = diff[SIGNAL_W-1:0];
		end else if (diff[SIGNAL_W]) begin
			diff_sat = SIG_MIN;
		end else begin
			diff_sat = SIG_MAX;
		end
	end

	always_ff @(posedge clk1 or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_error <= '0;
			o_dac_valid <= 1'b0;
		end else begin
			o_dac_valid <= valid;
			if (valid) begin
				o_error <= diff_sat;
			end
		end
	end

	// dac takes the msbs of the error
	assign o_dac_word = o_error[SIGNAL_W-1 -: DAC_W];

	// both filters share one strobe and one latency
	valid_pair_a: assert property (@(posedge clk1) disable iff (!i_rst_n)
		i_valid0 == i_valid1);

endmodule

// File: verilog/iir_first_order.sv
`timescale 1ns/1ns

module iir_first_order #(
	parameter int ADC_W     = servo_pkg::ADC_W,
	parameter int SIGNAL_W  = servo_pkg::SIGNAL_W,
	parameter int COEF_W    = servo_pkg::COEF_W,
	parameter int COEF_FRAC = servo_pkg::COEF_FRAC
) (
	input  logic                        clk1,
	input  logic                        i_rst_n,
	// filter on, bypass when low
	input  logic                        i_on,
	input  logic signed [COEF_W-1:0]    i_a1,
	input  logic signed [COEF_W-1:0]    i_b0,
	input  logic signed [COEF_W-1:0]    i_b1,
	input  logic signed [ADC_W-1:0]     i_sample,
	input  logic                        i_valid,
	output logic signed [SIGNAL_W-1:0]  o_signal,
	output logic                        o_valid
);

	// adc sample moves to the top of the signal word
	localparam int SHIFT = SIGNAL_W - ADC_W;
	localparam int PROD_W = COEF_W + SIGNAL_W;
	// two guard bits for the three term sum
	localparam int ACC_W = PROD_W + 2;
	localparam logic signed [SIGNAL_W-1:0] SIG_MAX = {1'b0, {(SIGNAL_W-1){1'b1}}};
	localparam logic signed [SIGNAL_W-1:0] SIG_MIN = {1'b1, {(SIGNAL_W-1){1'b0}}};

	logic signed [SIGNAL_W-1:0] xs;
	logic signed [SIGNAL_W-1:0] xs_prev;
	logic signed [PROD_W-1:0]   p_a1;
	logic signed [PROD_W-1:0]   p_b0;
	logic signed [PROD_W-1:0]   p_b1;
	logic signed [ACC_W-1:0]    acc;
	logic signed [ACC_W-1:0]    acc_sh;
	logic                       ovf;
	logic signed [SIGNAL_W-1:0] y_sat;

	//////////////////////////////////////////////////////////////////////
	// y[n] = a1*y[n-1] + b0*x[n] + b1*x[n-1]
	//////////////////////////////////////////////////////////////////////

	assign xs = SIGNAL_W'(i_sample) <<< SHIFT;

	// o_signal doubles as y[n-1]
	assign p_a1 = i_a1 * o_signal;
	assign p_b0 = i_b0 * xs;
	assign p_b1 = i_b1 * xs_prev;
	assign acc = p_a1 + p_b0 + p_b1;

	// drop the coefficient fraction
	assign acc_sh = acc >>> COEF_FRAC;

	// bits above the signal msb must all match the sign
	assign ovf = acc_sh[ACC_W-1:SIGNAL_W-1] != {(ACC_W-SIGNAL_W+1){acc_sh[ACC_W-1]}};

	always_comb begin
		if (!ovf) begin
			y_sat = acc_sh[SIGNAL_W-1:0];
		end else if (acc_sh[ACC_W-1]) begin
			y_sat = SIG_MIN;
		end else begin
			y_sat = SIG_MAX;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// state update
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk1 or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_signal <= '0;
			xs_prev <= '0;
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid;
			if (i_valid) begin
				// history tracks in bypass too
				o_signal <= i_on ? y_sat : xs;
				xs_prev <= xs;
			end
		end
	end

	// output strobe is the input strobe delayed once
	valid_follow_a: assert property (@(posedge clk1) disable iff (!i_rst_n)
		$rose(o_valid) |-> $past(i_valid));

endmodule

// File: verilog/servo_pkg.sv
package servo_pkg;

	//////////////////////////////////////////////////////////////////////
	// sample path widths
	//////////////////////////////////////////////////////////////////////

	// raw sample from each adc channel
	localparam int ADC_W = 16;
	// internal filtered signal, adc sample sits in the top bits
	localparam int SIGNAL_W = 24;
	// signed filter coefficient, 65536 is unity
	localparam int COEF_W = 18;
	localparam int COEF_FRAC = 16;
	// fast dac word, top bits of the error
	localparam int DAC_W = 16;

	//////////////////////////////////////////////////////////////////////
	// wishbone register bank
	//////////////////////////////////////////////////////////////////////

	// word address and data widths
	localparam int WB_AW = 4;
	localparam int WB_DW = 32;

	// firmware version, read only at address 0
	localparam logic [WB_DW-1:0] FW_VERSION = 32'h0000_0012;

	// one word per register
	typedef enum logic [WB_AW-1:0] {
		REG_VERSION = 4'd0,
		// filter on bits and afe gain settings
		REG_CONTROL = 4'd1,
		// channel 0 coefficients
		REG_A1_0    = 4'd2,
		REG_B0_0    = 4'd3,
		REG_B1_0    = 4'd4,
		// channel 1 coefficients
		REG_A1_1    = 4'd5,
		REG_B0_1    = 4'd6,
		REG_B1_1    = 4'd7
	} reg_addr_e;

endpackage

// File: verilog/servo_regs.sv
`timescale 1ns/1ns

module servo_regs #(
	parameter int COEF_W = servo_pkg::COEF_W
) (
	input  logic                          clk1,
	input  logic                          i_rst_n,
	// wishbone classic slave
	input  logic                          i_wb_cyc,
	input  logic                          i_wb_stb,
	input  logic                          i_wb_we,
	input  logic [servo_pkg::WB_AW-1:0]   i_wb_adr,
	input  logic [servo_pkg::WB_DW-1:0]   i_wb_dat,
	output logic [servo_pkg::WB_DW-1:0]   o_wb_dat,
	output logic                          o_wb_ack,
	// filter configuration
	output logic                          o_filt_on0,
	output logic                          o_filt_on1,
	output logic signed [COEF_W-1:0]      o_a1_0,
	output logic signed [COEF_W-1:0]      o_b0_0,
	output logic signed [COEF_W-1:0]      o_b1_0,
	output logic signed [COEF_W-1:0]      o_a1_1,
	output logic signed [COEF_W-1:0]      o_b0_1,
	output logic signed [COEF_W-1:0]      o_b1_1,
	// front end gain codes
	output logic [1:0]                    o_afe_gain0,
	output logic [1:0]                    o_afe_gain1
);

	import servo_pkg::*;

	// a1, b0, b1 for channel 0 then channel 1
	localparam int NUM_COEF = 6;

	reg_addr_e                 addr;
	logic                      wb_req;
	logic                      wb_new;
	logic [2:0]                coef_sel;
	logic [5:0]                ctrl_q;
	logic signed [COEF_W-1:0]  coef_q [NUM_COEF];
	logic [WB_DW-1:0]          rd_data;

	//////////////////////////////////////////////////////////////////////
	// bus decode
	//////////////////////////////////////////////////////////////////////

	assign addr = reg_addr_e'(i_wb_adr);
	assign wb_req = i_wb_cyc & i_wb_stb;
	// first cycle of a request, not the ack cycle
	assign wb_new = wb_req & ~o_wb_ack;
	// coefficient slot, only meaningful for addresses 2..7
	assign coef_sel = 3'(addr - REG_A1_0);

	// single cycle ack, write lands on the same edge
	always_ff @(posedge clk1 or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_wb_ack <= 1'b0;
			ctrl_q <= '0;
			for (int i = 0; i < NUM_COEF; i++) begin
				coef_q[i] <= '0;
			end
		end else begin
			o_wb_ack <= wb_new;
			if (wb_new && i_wb_we) begin
				case (addr)
					REG_CONTROL: begin
						ctrl_q <= i_wb_dat[5:0];
					end
					REG_A1_0, REG_B0_0, REG_B1_0,
					REG_A1_1, REG_B0_1, REG_B1_1: begin
						// keep the low COEF_W bits
						coef_q[coef_sel] <= i_wb_dat[COEF_W-1:0];
					end
					// version and holes are read only
					default: begin
					end
				endcase
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read back
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (addr)
			REG_VERSION: begin
				rd_data = FW_VERSION;
			end
			REG_CONTROL: begin
				rd_data = {{(WB_DW-6){1'b0}}, ctrl_q};
			end
			REG_A1_0, REG_B0_0, REG_B1_0,
			REG_A1_1, REG_B0_1, REG_B1_1: begin
				// sign extend to bus width
				rd_data = {{(WB_DW-COEF_W){coef_q[coef_sel][COEF_W-1]}}, coef_q[coef_sel]};
			end
			default: begin
				rd_data = '0;
			end
		endcase
	end

	// held through the ack cycle
	always_ff @(posedge clk1) begin
		if (wb_new) begin
			o_wb_dat <= rd_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// configuration out
	//////////////////////////////////////////////////////////////////////

	assign o_filt_on0 = ctrl_q[0];
	assign o_filt_on1 = ctrl_q[1];
	assign o_a1_0 = coef_q[0];
	assign o_b0_0 = coef_q[1];
	assign o_b1_0 = coef_q[2];
	assign o_a1_1 = coef_q[3];
	assign o_b0_1 = coef_q[4];
	assign o_b1_1 = coef_q[5];

	// board gain control is inverted
	assign o_afe_gain0 = 2'd3 - ctrl_q[3:2];
	assign o_afe_gain1 = 2'd3 - ctrl_q[5:4];

	// ack drops for at least one cycle between transfers
	ack_gap_a: assert property (@(posedge clk1) disable iff (!i_rst_n)
		o_wb_ack |=> !o_wb_ack);

endmodule

// File: verilog/servo_top.sv
`timescale 1ns/1ns

module servo_top #(
	parameter int ADC_W     = servo_pkg::ADC_W,
	parameter int SIGNAL_W  = servo_pkg::SIGNAL_W,
	parameter int COEF_W    = servo_pkg::COEF_W,
	parameter int COEF_FRAC = servo_pkg::COEF_FRAC,
	parameter int DAC_W     = servo_pkg::DAC_W
) (
	input  logic                          clk1,
	input  logic                          i_rst_n,
	// wishbone classic slave
	input  logic                          i_wb_cyc,
	input  logic                          i_wb_stb,
	input  logic                          i_wb_we,
	input  logic [servo_pkg::WB_AW-1:0]   i_wb_adr,
	input  logic [servo_pkg::WB_DW-1:0]   i_wb_dat,
	output logic [servo_pkg::WB_DW-1:0]   o_wb_dat,
	output logic                          o_wb_ack,
	// adc samples, one shared strobe
	input  logic signed [ADC_W-1:0]       i_adc0,
	input  logic signed [ADC_W-1:0]       i_adc1,
	input  logic                          i_sample_valid,
	// fast dac and error out
	output logic signed [DAC_W-1:0]       o_dac_word,
	output logic                          o_dac_valid,
	output logic signed [SIGNAL_W-1:0]    o_error,
	// analog front end gain codes
	output logic [1:0]                    o_afe_gain0,
	output logic [1:0]                    o_afe_gain1
);

	//////////////////////////////////////////////////////////////////////
	// configuration
	//////////////////////////////////////////////////////////////////////

	logic                       filt_on0;
	logic                       filt_on1;
	logic signed [COEF_W-1:0]   a1_0;
	logic signed [COEF_W-1:0]   b0_0;
	logic signed [COEF_W-1:0]   b1_0;
	logic signed [COEF_W-1:0]   a1_1;
	logic signed [COEF_W-1:0]   b0_1;
	logic signed [COEF_W-1:0]   b1_1;

	servo_regs #(
		.COEF_W(COEF_W)
	) regs_i (
		.clk1(clk1),
		.i_rst_n(i_rst_n),
		.i_wb_cyc(i_wb_cyc),
		.i_wb_stb(i_wb_stb),
		.i_wb_we(i_wb_we),
		.i_wb_adr(i_wb_adr),
		.i_wb_dat(i_wb_dat),
		.o_wb_dat(o_wb_dat),
		.o_wb_ack(o_wb_ack),
		.o_filt_on0(filt_on0),
		.o_filt_on1(filt_on1),
		.o_a1_0(a1_0),
		.o_b0_0(b0_0),
		.o_b1_0(b1_0),
		.o_a1_1(a1_1),
		.o_b0_1(b0_1),
		.o_b1_1(b1_1),
		.o_afe_gain0(o_afe_gain0),
		.o_afe_gain1(o_afe_gain1)
	);

	//////////////////////////////////////////////////////////////////////
	// per channel low pass, both in lock step
	//////////////////////////////////////////////////////////////////////

	logic signed [SIGNAL_W-1:0] sig0;
	logic signed [SIGNAL_W-1:0] sig1;
	logic                       sig0_valid;
	logic                       sig1_valid;

	iir_first_order #(
		.ADC_W(ADC_W),
		.SIGNAL_W(SIGNAL_W),
		.COEF_W(COEF_W),
		.COEF_FRAC(COEF_FRAC)
	) iir0_i (
		.clk1(clk1),
		.i_rst_n(i_rst_n),
		.i_on(filt_on0),
		.i_a1(a1_0),
		.i_b0(b0_0),
		.i_b1(b1_0),
		.i_sample(i_adc0),
		.i_valid(i_sample_valid),
		.o_signal(sig0),
		.o_valid(sig0_valid)
	);

	iir_first_order #(
		.ADC_W(ADC_W),
		.SIGNAL_W(SIGNAL_W),
		.COEF_W(COEF_W),
		.COEF_FRAC(COEF_FRAC)
	) iir1_i (
		.clk1(clk1),
		.i_rst_n(i_rst_n),
		.i_on(filt_on1),
		.i_a1(a1_1),
		.i_b0(b0_1),
		.i_b1(b1_1),
		.i_sample(i_adc1),
		.i_valid(i_sample_valid),
		.o_signal(sig1),
		.o_valid(sig1_valid)
	);

	// error = ch0 - ch1, saturated
	channel_diff #(
		.SIGNAL_W(SIGNAL_W),
		.DAC_W(DAC_W)
	) diff_i (
		.clk1(clk1),
		.i_rst_n(i_rst_n),
		.i_sig0(sig0),
		.i_sig1(sig1),
		.i_valid0(sig0_valid),
		.i_valid1(sig1_valid),
		.o_error(o_error),
		.o_dac_word(o_dac_word),
		.o_dac_valid(o_dac_valid)
	);

endmodule
